// ==== rv_pkg.sv ====
package rv_pkg;

    // immediate slicing in imm_gen assumes a 32-bit word.
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;   // register, operand and memory data.
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;

    // base opcodes of the supported RV32I subset.
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // write-back source.
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    // first ALU operand: normal, AUIPC, LUI.
    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } a_sel_t;

endpackage

// ==== alu.sv ====
module alu import rv_pkg::*; (
    input  xlen_t   a,
    input  xlen_t   b,
    input  alu_op_t op,
    output xlen_t   result,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // only the low five bits shift.

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // used by BEQ and BNE after a subtract.
    assign zero = (result == '0);

endmodule

// ==== alu_control.sv ====
module alu_control import rv_pkg::*; (
    input  opcode_t    opcode,
    input  logic [2:0] funct3,
    input  logic       bit30,
    output alu_op_t    op
);

    always_comb begin
        op = ALU_ADD;   // address and link arithmetic.
        case (opcode)
            OP_REG, OP_IMM: begin
                case (funct3)
                    // addi has no subtract form, bit 30 is immediate there.
                    3'b000: op = (opcode == OP_REG && bit30) ? ALU_SUB : ALU_ADD;
                    3'b001: op = ALU_SLL;
                    3'b010: op = ALU_SLT;
                    3'b011: op = ALU_SLTU;
                    3'b100: op = ALU_XOR;
                    3'b101: op = bit30 ? ALU_SRA : ALU_SRL;
                    3'b110: op = ALU_OR;
                    default: op = ALU_AND;
                endcase
            end
            OP_BRANCH: begin
                case (funct3[2:1])
                    2'b10:   op = ALU_SLT;    // blt, bge.
                    2'b11:   op = ALU_SLTU;   // bltu, bgeu.
                    default: op = ALU_SUB;    // beq, bne.
                endcase
            end
            default: op = ALU_ADD;
        endcase
    end

endmodule

// ==== main_control.sv ====
module main_control import rv_pkg::*; (
    input  opcode_t opcode,
    output logic    branch,
    output logic    jump,
    output logic    jalr,
    output logic    mem_write,
    output logic    alu_src_imm,
    output logic    reg_write,
    output wb_sel_t wb_sel,
    output a_sel_t  a_sel
);

    always_comb begin
        // unknown opcodes fall through as a no-op.
        branch      = 1'b0;
        jump        = 1'b0;
        jalr        = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        wb_sel      = WB_ALU;
        a_sel       = A_RS1;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
            end
            OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;   // address is rs1 + imm.
            end
            OP_BRANCH: begin
                branch = 1'b1;   // ALU compares rs1 and rs2.
            end
            OP_JAL: begin
                jump      = 1'b1;
                reg_write = 1'b1;
                wb_sel    = WB_PC4;
            end
            OP_JALR: begin
                jalr        = 1'b1;
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;   // target comes out of the ALU.
                wb_sel      = WB_PC4;
            end
            OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_sel       = A_ZERO;
            end
            OP_AUIPC: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_sel       = A_PC;
            end
            default: ;
        endcase
    end

endmodule

// ==== imm_gen.sv ====
module imm_gen import rv_pkg::*; (
    input  xlen_t inst,
    output xlen_t imm
);

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm = {{20{inst[31]}}, inst[31:20]};
            OP_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OP_BRANCH:   // byte offset, bit 0 always clear.
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {inst[31:12], 12'b0};
            OP_JAL:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;   // R-type carries no immediate.
        endcase
    end

endmodule

// ==== reg_file.sv ====
module reg_file import rv_pkg::*; (
    input  logic     CLK,
    input  logic     RESET_N,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  xlen_t    wdata,
    input  logic     we,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;   // x0 is never written, so it stays zero.
        end
    end

    // combinational reads, new value visible after the edge.
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== rv_core.sv ====
module rv_core import rv_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  xlen_t                 idata,
    output logic [ADDR_WIDTH-1:0] iaddr,
    output logic [ADDR_WIDTH-1:0] daddr,
    input  xlen_t                 ddata_r,
    output xlen_t                 ddata_w,
    output logic                  d_rw
);

    xlen_t      pc;             // byte address.
    xlen_t      pc_plus4;
    xlen_t      pc_next;
    xlen_t      branch_target;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      imm;
    xlen_t      alu_a;
    xlen_t      alu_b;
    xlen_t      alu_result;
    xlen_t      wb_data;
    logic       alu_zero;
    logic       cond;
    logic       branch_taken;
    logic [2:0] funct3;

    alu_op_t alu_op;
    wb_sel_t wb_sel;
    a_sel_t  a_sel;
    logic    branch;
    logic    jump;
    logic    jalr;
    logic    mem_write;
    logic    alu_src_imm;
    logic    reg_write;

    assign funct3 = idata[14:12];

    main_control u_main_control (
        .opcode      (idata[6:0]),
        .branch      (branch),
        .jump        (jump),
        .jalr        (jalr),
        .mem_write   (mem_write),
        .alu_src_imm (alu_src_imm),
        .reg_write   (reg_write),
        .wb_sel      (wb_sel),
        .a_sel       (a_sel)
    );

    alu_control u_alu_control (
        .opcode (idata[6:0]),
        .funct3 (funct3),
        .bit30  (idata[30]),
        .op     (alu_op)
    );

    imm_gen u_imm_gen (
        .inst (idata),
        .imm  (imm)
    );

    reg_file u_reg_file (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (idata[19:15]),
        .rs2     (idata[24:20]),
        .rd      (idata[11:7]),
        .wdata   (wb_data),
        .we      (reg_write),
        .rdata1  (rs1_data),
        .rdata2  (rs2_data)
    );

    always_comb begin
        case (a_sel)
            A_PC:    alu_a = pc;   // auipc.
            A_ZERO:  alu_a = '0;   // lui passes the immediate through.
            default: alu_a = rs1_data;
        endcase
    end

    assign alu_b = alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = ddata_r;
            WB_PC4:  wb_data = pc_plus4;   // link address.
            default: wb_data = alu_result;
        endcase
    end

    // funct3[2] picks the compare flag, odd funct3 negates it.
    assign cond          = funct3[2] ? alu_result[0] : alu_zero;
    assign branch_taken  = branch & (cond ^ funct3[0]);
    assign branch_target = pc + imm;

    always_comb begin
        if (jalr) begin
            pc_next = {alu_result[XLEN-1:1], 1'b0};
        end else if (jump || branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign iaddr   = pc[ADDR_WIDTH+1:2];           // word address.
    assign daddr   = alu_result[ADDR_WIDTH+1:2];
    assign ddata_w = rs2_data;
    assign d_rw    = mem_write;

endmodule

// ==== rv_core_chk.sv ====
module rv_core_chk import rv_pkg::*; (
    input logic  CLK,
    input logic  RESET_N,
    input xlen_t idata,
    input logic  d_rw,
    input xlen_t pc,
    input xlen_t x0_val
);

    int fail_count = 0;

    store_only: assert property (@(posedge CLK) disable iff (!RESET_N)
        d_rw |-> idata[6:0] == OP_STORE)
        else begin
            fail_count++;
            $error("d_rw high for a non-store opcode %h", idata[6:0]);
        end

    pc_aligned: assert property (@(posedge CLK) disable iff (!RESET_N) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc %h is not word aligned", pc);
        end

    x0_zero: assert property (@(posedge CLK) disable iff (!RESET_N) x0_val == '0)
        else begin
            fail_count++;
            $error("register x0 reads %h instead of zero", x0_val);
        end

endmodule

bind rv_core rv_core_chk u_chk (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .idata   (idata),
    .d_rw    (d_rw),
    .pc      (pc),
    .x0_val  (u_reg_file.regs[0])
);

// ==== rv_checker.sv ====
module rv_checker import rv_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input logic                  CLK,
    input logic                  RESET_N,
    input xlen_t                 idata,
    input logic [ADDR_WIDTH-1:0] iaddr,
    input logic [ADDR_WIDTH-1:0] daddr,
    input xlen_t                 ddata_r,
    input xlen_t                 ddata_w,
    input logic                  d_rw
);

    int       errors = 0;   // read by the testbench for the closing line.
    xlen_t    model_regs [32];
    xlen_t    model_pc;
    xlen_t    next_pc;
    logic     wr_en;
    reg_idx_t wr_idx;
    xlen_t    wr_val;
    logic     st_en;
    xlen_t    mem_addr;
    xlen_t    st_data;

    // integer ops as the ISA defines them, alt selects sub or sra.
    function automatic xlen_t int_op(input logic [2:0] f3, input logic alt,
                                     input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void ref_step(
        input  xlen_t    rf [32],
        input  xlen_t    pc,
        input  xlen_t    inst,
        input  xlen_t    rdata,
        output xlen_t    nxt,
        output logic     we,
        output reg_idx_t rd,
        output xlen_t    val,
        output logic     st,
        output xlen_t    addr,
        output xlen_t    sdata
    );
        xlen_t      a;
        xlen_t      b;
        xlen_t      i_imm;
        xlen_t      s_imm;
        xlen_t      b_imm;
        xlen_t      j_imm;
        xlen_t      u_imm;
        logic [2:0] f3;
        logic       take;
        a     = rf[inst[19:15]];
        b     = rf[inst[24:20]];
        f3    = inst[14:12];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        u_imm = {inst[31:12], 12'b0};
        nxt   = pc + 32'd4;
        we    = 1'b0;
        rd    = inst[11:7];
        val   = '0;
        st    = 1'b0;
        addr  = a + i_imm;   // load address.
        sdata = b;
        take  = 1'b0;
        case (inst[6:0])
            OP_REG: begin
                we  = 1'b1;
                val = int_op(f3, inst[30], a, b);
            end
            OP_IMM: begin
                we  = 1'b1;
                val = int_op(f3, inst[30] && f3 == 3'b101, a, i_imm);
            end
            OP_LOAD: begin
                we  = 1'b1;
                val = rdata;
            end
            OP_STORE: begin
                st   = 1'b1;
                addr = a + s_imm;
            end
            OP_BRANCH: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    nxt = pc + b_imm;
                end
            end
            OP_JAL: begin
                we  = 1'b1;
                val = pc + 32'd4;
                nxt = pc + j_imm;
            end
            OP_JALR: begin
                we  = 1'b1;
                val = pc + 32'd4;
                nxt = (a + i_imm) & 32'hFFFF_FFFE;
            end
            OP_LUI: begin
                we  = 1'b1;
                val = u_imm;
            end
            OP_AUIPC: begin
                we  = 1'b1;
                val = pc + u_imm;
            end
            default: ;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input xlen_t expected, input xlen_t actual);
        $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    always @(posedge CLK) begin
        if (!RESET_N) begin
            model_pc = '0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            if (iaddr !== '0) begin
                report_mismatch("iaddr", '0, xlen_t'(iaddr));
            end
        end else begin
            ref_step(model_regs, model_pc, idata, ddata_r,
                     next_pc, wr_en, wr_idx, wr_val, st_en, mem_addr, st_data);
            if (iaddr !== model_pc[ADDR_WIDTH+1:2]) begin
                report_mismatch("iaddr", xlen_t'(model_pc[ADDR_WIDTH+1:2]), xlen_t'(iaddr));
            end
            if (d_rw !== st_en) begin
                report_mismatch("d_rw", xlen_t'(st_en), xlen_t'(d_rw));
            end
            if ((st_en || idata[6:0] == OP_LOAD) && daddr !== mem_addr[ADDR_WIDTH+1:2]) begin
                report_mismatch("daddr", xlen_t'(mem_addr[ADDR_WIDTH+1:2]), xlen_t'(daddr));
            end
            if (st_en && ddata_w !== st_data) begin
                report_mismatch("ddata_w", st_data, ddata_w);
            end
            if (wr_en && wr_idx != '0) begin
                model_regs[wr_idx] = wr_val;   // x0 stays zero.
            end
            model_pc = next_pc;
        end
    end

endmodule

// ==== tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*; ();

    localparam int    ADDR_WIDTH = 10;
    localparam xlen_t HALT       = 32'h0000_006f;   // jal x0, 0.

    logic                  CLK = 1'b0;
    logic                  RESET_N;
    xlen_t                 idata;
    xlen_t                 ddata_r;
    xlen_t                 ddata_w;
    logic [ADDR_WIDTH-1:0] iaddr;
    logic [ADDR_WIDTH-1:0] daddr;
    logic                  d_rw;

    xlen_t       imem [1024];
    xlen_t       dmem [1024];
    integer      seed;
    int          prog_len  = 0;
    int          cycles    = 0;
    int          halt_seen = 0;
    int          limit;
    int          total;
    logic        timed_out = 1'b0;
    logic [11:0] store_off = 12'h400;   // result area in data memory.

    always #5 CLK = ~CLK;

    // zero-wait memories.
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (RESET_N && d_rw) begin
            dmem[daddr] <= ddata_w;
        end
    end

    rv_core #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .idata   (idata),
        .iaddr   (iaddr),
        .daddr   (daddr),
        .ddata_r (ddata_r),
        .ddata_w (ddata_w),
        .d_rw    (d_rw)
    );

    rv_checker #(.ADDR_WIDTH(ADDR_WIDTH)) u_checker (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .idata   (idata),
        .iaddr   (iaddr),
        .daddr   (daddr),
        .ddata_r (ddata_r),
        .ddata_w (ddata_w),
        .d_rw    (d_rw)
    );

    function automatic xlen_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic xlen_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};   // sw.
    endfunction

    function automatic xlen_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic xlen_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic xlen_t j_type(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input xlen_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic store_reg(input reg_idx_t rs);
        emit(s_type(store_off, rs, 5'd0));
        store_off += 12'd4;
    endtask

    task automatic compute_and_store(input xlen_t inst);
        emit(inst);
        store_reg(inst[11:7]);
    endtask

    // x2 random, x3 most negative, x4 = -5, x5 = 31, x0 as shift of zero.
    task automatic reg_reg_cases(input logic [6:0] f7, input logic [2:0] f3);
        compute_and_store(r_type(f7, 5'd2, 5'd1, f3, 5'd10));
        compute_and_store(r_type(f7, 5'd4, 5'd3, f3, 5'd11));
        compute_and_store(r_type(f7, 5'd5, 5'd4, f3, 5'd12));
        compute_and_store(r_type(f7, 5'd0, 5'd1, f3, 5'd13));
    endtask

    // a taken branch skips the counter increment.
    task automatic branch_skip(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(i_type(12'd1, 5'd20, 3'b000, 5'd20, OP_IMM));
    endtask

    task automatic branch_cases(input logic [2:0] f3);
        branch_skip(f3, 5'd1, 5'd1);
        branch_skip(f3, 5'd4, 5'd5);
        branch_skip(f3, 5'd3, 5'd5);
        branch_skip(f3, 5'd5, 5'd3);
    endtask

    // auipc gives the base and jalr lands two instructions on.
    task automatic jalr_skip(input logic [11:0] off);
        emit(u_type(20'd0, 5'd22, OP_AUIPC));
        emit(i_type(off, 5'd22, 3'b000, 5'd23, OP_JALR));
        emit(i_type(12'd1, 5'd20, 3'b000, 5'd20, OP_IMM));
        store_reg(5'd23);
    endtask

    initial begin
        xlen_t rnd;
        RESET_N = 1'b0;
        seed    = 98403;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = $random(seed);
            imem[i] = i_type(i[11:0], 5'd0, 3'b000, 5'd0, OP_IMM);   // nop tagged with its address.
        end
        rnd = $random(seed);
        emit(i_type(12'h100, 5'd0, 3'b010, 5'd1, OP_LOAD));
        emit(i_type(12'h104, 5'd0, 3'b010, 5'd2, OP_LOAD));
        emit(u_type(20'h80000, 5'd3, OP_LUI));
        emit(i_type(12'hFFB, 5'd0, 3'b000, 5'd4, OP_IMM));
        emit(i_type(12'd31, 5'd0, 3'b000, 5'd5, OP_IMM));
        reg_reg_cases(7'h00, 3'b000);
        reg_reg_cases(7'h20, 3'b000);
        reg_reg_cases(7'h00, 3'b001);
        reg_reg_cases(7'h00, 3'b010);
        reg_reg_cases(7'h00, 3'b011);
        reg_reg_cases(7'h00, 3'b100);
        reg_reg_cases(7'h00, 3'b101);
        reg_reg_cases(7'h20, 3'b101);
        reg_reg_cases(7'h00, 3'b110);
        reg_reg_cases(7'h00, 3'b111);
        compute_and_store(i_type(rnd[11:0], 5'd1, 3'b000, 5'd14, OP_IMM));
        compute_and_store(i_type(12'h800, 5'd4, 3'b000, 5'd14, OP_IMM));
        compute_and_store(i_type(12'hFFC, 5'd4, 3'b010, 5'd14, OP_IMM));
        compute_and_store(i_type(rnd[23:12], 5'd1, 3'b010, 5'd14, OP_IMM));
        compute_and_store(i_type(12'hFFF, 5'd4, 3'b011, 5'd14, OP_IMM));
        compute_and_store(i_type(12'd1, 5'd1, 3'b011, 5'd14, OP_IMM));
        compute_and_store(i_type(rnd[31:20], 5'd1, 3'b100, 5'd14, OP_IMM));
        compute_and_store(i_type(12'hFFF, 5'd4, 3'b100, 5'd14, OP_IMM));
        compute_and_store(i_type(rnd[19:8], 5'd3, 3'b110, 5'd14, OP_IMM));
        compute_and_store(i_type(12'hF0F, 5'd2, 3'b111, 5'd14, OP_IMM));
        compute_and_store(i_type(12'd0, 5'd1, 3'b001, 5'd14, OP_IMM));
        compute_and_store(i_type(12'd31, 5'd1, 3'b001, 5'd14, OP_IMM));
        compute_and_store(i_type(12'd31, 5'd3, 3'b101, 5'd14, OP_IMM));
        compute_and_store(i_type(12'd0, 5'd1, 3'b101, 5'd14, OP_IMM));
        compute_and_store(i_type(12'h41F, 5'd3, 3'b101, 5'd14, OP_IMM));
        compute_and_store(i_type(12'h400, 5'd4, 3'b101, 5'd14, OP_IMM));
        compute_and_store(i_type(12'h40D, 5'd1, 3'b101, 5'd14, OP_IMM));
        rnd = $random(seed);
        compute_and_store(u_type(rnd[31:12], 5'd15, OP_LUI));
        compute_and_store(u_type(rnd[19:0], 5'd16, OP_AUIPC));
        // load, modify, store back and reload.
        emit(i_type(12'h108, 5'd0, 3'b010, 5'd7, OP_LOAD));
        emit(i_type(12'h07B, 5'd7, 3'b000, 5'd7, OP_IMM));
        emit(s_type(12'h108, 5'd7, 5'd0));
        emit(i_type(12'h108, 5'd0, 3'b010, 5'd8, OP_LOAD));
        compute_and_store(r_type(7'h20, 5'd2, 5'd8, 3'b000, 5'd8));
        branch_cases(3'b000);
        branch_cases(3'b001);
        branch_cases(3'b100);
        branch_cases(3'b101);
        branch_cases(3'b110);
        branch_cases(3'b111);
        emit(j_type(21'd8, 5'd21));
        emit(i_type(12'd1, 5'd20, 3'b000, 5'd20, OP_IMM));
        store_reg(5'd21);
        jalr_skip(12'd13);   // bit 0 of the odd target is dropped.
        jalr_skip(12'd12);
        emit(i_type(12'd5, 5'd1, 3'b000, 5'd0, OP_IMM));
        emit(i_type(12'h100, 5'd0, 3'b010, 5'd0, OP_LOAD));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd0));
        store_reg(5'd0);
        store_reg(5'd20);
        emit(HALT);
        limit = prog_len * 2 + 50;

        repeat (3) @(posedge CLK);
        RESET_N <= 1'b1;
        while (halt_seen < 8 && !timed_out) begin
            @(posedge CLK);
            cycles++;
            halt_seen = (idata == HALT) ? halt_seen + 1 : 0;
            if (cycles >= limit) begin
                timed_out = 1'b1;
                $display("timeout: no final self-jump after %0d cycles", cycles);
            end
        end
        @(negedge CLK);   // checks of the last edge have all run by now.

        total = u_checker.errors + DUT.u_chk.fail_count + int'(timed_out);
        $display("errors: checker %0d, assertions %0d, timeouts %0d",
                 u_checker.errors, DUT.u_chk.fail_count, int'(timed_out));
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
rv_pkg.sv
alu.sv
alu_control.sv
main_control.sv
imm_gen.sv
reg_file.sv
rv_core.sv
rv_core_chk.sv
rv_checker.sv
tb_rv_core.sv
